//--- bench/sparcDataPathTb.sv
// sparc datapath testbench: acts as the control unit and checks the datapath against models
`timescale 1ns/1ps

module sparcDataPathTb import sparcDpPkg::*; ();

    // tests take a few hundred cycles
    localparam int     cycleLimit = 2000;
    localparam longint maxInt     = 64'sd2147483647;
    localparam longint minInt     = -64'sd2147483648;

    logic    Clk;
    logic    arstN;
    logic    pcEn, nPcEn, marEn, mdrEn, irEn, memStart, memWrite;
    logic    rfWe, raSel, rcSel, aopSel, flagsEn, cwpWe;
    nPcSel_t nPcSel;
    marSel_t marSel;
    mdrSel_t mdrSel;
    cinSel_t cinSel;
    opBSel_t opBSel;
    op3_t    opExt;
    cwp_t    cwpIn;
    word_t   extAddr, extData;
    word_t   pc, nPc, ir, mdr, aluResult;
    flags_t  flags;
    cwp_t    cwp;
    logic    memDone;

    // reference state
    word_t  memModel [64];
    word_t  regModel [72];
    word_t  pcModel;
    word_t  nPcModel;
    flags_t flagsModel;
    cwp_t   cwpModel;
    word_t  lcgState = 32'hfbc72406;
    int     cycleCount = 0;

    sparcDataPath #(.memWords(64)) u_dut (.*);

    initial Clk = 1'b0;
    always #2 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount == cycleLimit) begin
            $display("timeout: tests did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    function automatic word_t nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // window w: r8..r31 start at physical 8 + w*16, wrapping over 64
    function automatic int physIndex(regAddr_t r, cwp_t w);
        if (r < 8) begin
            return int'(r);
        end
        return 8 + ((int'(w) * 16 + int'(r) - 8) % 64);
    endfunction

    function automatic word_t readReg(regAddr_t r);
        if (r == 0) begin
            return '0;
        end
        return regModel[physIndex(r, cwpModel)];
    endfunction

    function automatic word_t operandB(word_t instr, opBSel_t sel);
        case (sel)
            opBReg:    return readReg(instr[4:0]);
            opBSimm13: return {{19{instr[12]}}, instr[12:0]};
            opBSethi:  return {instr[21:0], 10'b0};
            default:   return '0;
        endcase
    endfunction

    function automatic word_t fmt3Reg(regAddr_t rd, op3_t op, regAddr_t rs1, regAddr_t rs2);
        return {2'b10, rd, op, rs1, 1'b0, 8'b0, rs2};
    endfunction

    function automatic word_t fmt3Imm(regAddr_t rd, op3_t op, regAddr_t rs1, logic [12:0] simm);
        return {2'b10, rd, op, rs1, 1'b1, simm};
    endfunction

    task automatic checkValue(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("** Error: %s got %h expected %h", name, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic nextCycle();
        @(posedge Clk);
        #1;
    endtask

    task automatic idleControls();
        pcEn = 1'b0;
        nPcEn = 1'b0;
        marEn = 1'b0;
        mdrEn = 1'b0;
        irEn = 1'b0;
        memStart = 1'b0;
        memWrite = 1'b0;
        rfWe = 1'b0;
        raSel = 1'b0;
        rcSel = 1'b0;
        aopSel = 1'b0;
        flagsEn = 1'b0;
        cwpWe = 1'b0;
        nPcSel = nPcIncr;
        marSel = marExt;
        mdrSel = mdrExt;
        cinSel = cinMdr;
        opBSel = opBReg;
        opExt = op3Add;
        cwpIn = '0;
        extAddr = '0;
        extData = '0;
    endtask

    // IR only loads through the MDR
    task automatic loadIr(input word_t instr);
        mdrSel = mdrExt;
        extData = instr;
        mdrEn = 1'b1;
        nextCycle();
        mdrEn = 1'b0;
        irEn = 1'b1;
        nextCycle();
        irEn = 1'b0;
        checkValue("ir", ir, instr);
    endtask

    task automatic writeReg(input regAddr_t rd, input word_t value);
        loadIr(fmt3Reg(rd, op3Or, 0, 0));
        extData = value;
        mdrEn = 1'b1;
        nextCycle();
        mdrEn = 1'b0;
        rfWe = 1'b1;
        rcSel = 1'b0;
        cinSel = cinMdr;
        nextCycle();
        rfWe = 1'b0;
        if (rd != 0) begin
            regModel[physIndex(rd, cwpModel)] = value;
        end
    endtask

    task automatic writeMem(input word_t addr, input word_t data);
        marSel = marExt;
        extAddr = addr;
        marEn = 1'b1;
        mdrSel = mdrExt;
        extData = data;
        mdrEn = 1'b1;
        nextCycle();
        marEn = 1'b0;
        mdrEn = 1'b0;
        memStart = 1'b1;
        memWrite = 1'b1;
        nextCycle();
        memStart = 1'b0;
        memWrite = 1'b0;
        memModel[addr[7:2]] = data;
        checkValue("memDone", word_t'(memDone), 32'd1);
        nextCycle();
        checkValue("memDone", word_t'(memDone), 32'd0);
    endtask

    task automatic readMem(input marSel_t src, input word_t addr);
        marSel = src;
        extAddr = addr;
        marEn = 1'b1;
        nextCycle();
        marEn = 1'b0;
        mdrSel = mdrMem;
        mdrEn = 1'b1;
        memStart = 1'b1;
        nextCycle();
        mdrEn = 1'b0;
        memStart = 1'b0;
        checkValue("memDone", word_t'(memDone), 32'd1);
        checkValue("mdr", mdr, memModel[addr[7:2]]);
    endtask

    task automatic aluReference(input op3_t op, input word_t a, input word_t b,
                                output word_t res, output flags_t f);
        longint s;
        logic   v;
        logic   c;
        v = 1'b0;
        c = 1'b0;
        case (op)
            op3Add, op3Addcc: begin
                res = a + b;
                c = res < a;
                s = longint'($signed(a)) + longint'($signed(b));
                v = (s > maxInt) || (s < minInt);
            end
            op3Sub, op3Subcc: begin
                res = a - b;
                // borrow
                c = a < b;
                s = longint'($signed(a)) - longint'($signed(b));
                v = (s > maxInt) || (s < minInt);
            end
            op3And, op3Andcc: res = a & b;
            op3Or, op3Orcc:   res = a | b;
            op3Xor, op3Xorcc: res = a ^ b;
            op3Andn:          res = a & ~b;
            op3Orn:           res = a | ~b;
            op3Xnor:          res = a ~^ b;
            op3Sll:           res = a << b[4:0];
            op3Srl:           res = a >> b[4:0];
            op3Sra:           res = word_t'($signed(a) >>> b[4:0]);
            default:          res = '0;
        endcase
        f = {res[31], res == 0, v, c};
    endtask

    // selects stay as set so aluResult remains valid for the caller
    task automatic execOp(input word_t instr, input op3_t op, input opBSel_t bSel,
                          input logic doFlags);
        word_t  expRes;
        flags_t expFlags;
        loadIr(instr);
        // format 3 takes op3 from the IR, anything else from opExt
        aopSel = (instr[31:30] != 2'b10);
        opExt = op;
        opBSel = bSel;
        flagsEn = doFlags;
        #1;
        aluReference(op, readReg(instr[18:14]), operandB(instr, bSel), expRes, expFlags);
        checkValue("aluResult", aluResult, expRes);
        nextCycle();
        flagsEn = 1'b0;
        if (doFlags && op[4]) begin
            flagsModel = expFlags;
        end
        checkValue("flags", word_t'(flags), word_t'(flagsModel));
    endtask

    task automatic stepFetch(input nPcSel_t sel, input logic nPcOn, input word_t target,
                             input logic link);
        pcEn = 1'b1;
        nPcEn = nPcOn;
        nPcSel = sel;
        rfWe = link;
        rcSel = link;
        cinSel = cinPc;
        nextCycle();
        pcEn = 1'b0;
        nPcEn = 1'b0;
        rfWe = 1'b0;
        rcSel = 1'b0;
        if (link) begin
            regModel[physIndex(15, cwpModel)] = pcModel;
        end
        pcModel = nPcModel;
        nPcModel = target;
        checkValue("pc", pc, pcModel);
        checkValue("nPc", nPc, nPcModel);
    endtask

    task automatic setWindow(input cwp_t w);
        cwpIn = w;
        cwpWe = 1'b1;
        nextCycle();
        cwpWe = 1'b0;
        cwpModel = w;
        checkValue("cwp", word_t'(cwp), word_t'(cwpModel));
    endtask

    task automatic checkReset();
        pcModel = 32'h0;
        nPcModel = 32'h4;
        flagsModel = '0;
        cwpModel = '0;
        checkValue("pc", pc, pcModel);
        checkValue("nPc", nPc, nPcModel);
        checkValue("ir", ir, 32'h0);
        checkValue("mdr", mdr, 32'h0);
        checkValue("flags", word_t'(flags), 32'h0);
        checkValue("cwp", word_t'(cwp), 32'h0);
        checkValue("memDone", word_t'(memDone), 32'h0);
    endtask

    task automatic memoryTest();
        for (int i = 0; i < 8; i++) begin
            writeMem(word_t'(i * 4), nextRand());
        end
        for (int i = 0; i < 8; i++) begin
            readMem(marExt, word_t'(i * 4));
        end
        // instruction fetch from pc
        readMem(marPc, pcModel);
        irEn = 1'b1;
        nextCycle();
        irEn = 1'b0;
        checkValue("ir", ir, memModel[0]);
    endtask

    task automatic aluTest();
        word_t r;
        writeReg(1, 32'h7fff_ffff);
        writeReg(2, 32'h1);
        writeReg(3, 32'hffff_ffff);
        writeReg(10, 32'd5);
        writeReg(4, nextRand());
        writeReg(6, nextRand() | 32'h8000_0000);
        // signed overflow, then zero with carry, then borrow
        execOp(fmt3Reg(0, op3Addcc, 1, 2), op3Addcc, opBReg, 1'b1);
        execOp(fmt3Reg(0, op3Addcc, 3, 2), op3Addcc, opBReg, 1'b1);
        execOp(fmt3Reg(0, op3Subcc, 2, 3), op3Subcc, opBReg, 1'b1);
        execOp(fmt3Reg(0, op3Subcc, 1, 1), op3Subcc, opBReg, 1'b1);
        execOp(fmt3Reg(0, op3Andcc, 4, 6), op3Andcc, opBReg, 1'b1);
        execOp(fmt3Imm(0, op3Orcc, 4, 13'h1f80), op3Orcc, opBSimm13, 1'b1);
        execOp(fmt3Reg(0, op3Xorcc, 4, 4), op3Xorcc, opBReg, 1'b1);
        // flags must hold here
        execOp(fmt3Reg(0, op3Subcc, 2, 1), op3Subcc, opBReg, 1'b0);
        execOp(fmt3Reg(0, op3Add, 1, 2), op3Add, opBReg, 1'b1);
        execOp(fmt3Reg(0, op3Sll, 4, 10), op3Sll, opBReg, 1'b1);
        execOp(fmt3Imm(0, op3Srl, 6, 13'h23), op3Srl, opBSimm13, 1'b1);
        execOp(fmt3Imm(0, op3Sra, 6, 13'h7), op3Sra, opBSimm13, 1'b1);
        // sethi with rs1 field of r0
        r = nextRand();
        execOp({2'b00, 5'd0, 3'b100, r[21:19], 5'b0, r[13:0]}, op3Add, opBSethi, 1'b0);
        for (int i = 0; i < 4; i++) begin
            writeReg(4, nextRand());
            writeReg(5, nextRand());
            execOp(fmt3Reg(0, op3Addcc, 4, 5), op3Addcc, opBReg, 1'b1);
            execOp(fmt3Reg(0, op3Subcc, 4, 5), op3Subcc, opBReg, 1'b1);
        end
    endtask

    task automatic windowTest();
        word_t v8;
        word_t v3;
        v8 = nextRand();
        v3 = nextRand();
        setWindow(1);
        writeReg(8, v8);
        writeReg(3, v3);
        execOp(fmt3Imm(0, op3Or, 8, 0), op3Or, opBSimm13, 1'b0);
        checkValue("r8 in window 1", aluResult, v8);
        setWindow(0);
        // outs of window 1 are the ins of window 0
        execOp(fmt3Imm(0, op3Or, 24, 0), op3Or, opBSimm13, 1'b0);
        checkValue("r24 in window 0", aluResult, v8);
        execOp(fmt3Imm(0, op3Or, 3, 0), op3Or, opBSimm13, 1'b0);
        checkValue("r3 global", aluResult, v3);
        writeReg(0, nextRand());
        execOp(fmt3Imm(0, op3Or, 0, 0), op3Or, opBSimm13, 1'b0);
        checkValue("r0", aluResult, 32'h0);
    endtask

    task automatic pcTest();
        word_t disp;
        word_t link;
        stepFetch(nPcIncr, 1'b1, nPcModel + 32'd4, 1'b0);
        // disp22 of -3 then +100
        loadIr({2'b00, 5'd0, 3'b010, 22'h3f_fffd});
        stepFetch(nPcBranch, 1'b1, pcModel - 32'd12, 1'b0);
        loadIr({2'b00, 5'd0, 3'b010, 22'd100});
        stepFetch(nPcBranch, 1'b1, pcModel + 32'd400, 1'b0);
        disp = nextRand();
        loadIr({2'b01, disp[29:0]});
        link = pcModel;
        stepFetch(nPcCall, 1'b1, pcModel + {disp[29:0], 2'b00}, 1'b1);
        execOp(fmt3Imm(0, op3Or, 15, 0), op3Or, opBSimm13, 1'b0);
        checkValue("r15 link", aluResult, link);
        execOp(fmt3Imm(0, op3Or, 0, 13'h100), op3Or, opBSimm13, 1'b0);
        stepFetch(nPcAlu, 1'b1, 32'h100, 1'b0);
        // pc alone advances, nPc holds
        stepFetch(nPcIncr, 1'b0, nPcModel, 1'b0);
    endtask

    initial begin
        idleControls();
        arstN = 1'b0;
        repeat (3) @(posedge Clk);
        #1;
        arstN = 1'b1;
        checkReset();
        memoryTest();
        aluTest();
        windowTest();
        pcTest();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- rtl/aluUnit.sv
// ALU unit: operand B select, integer ALU, condition codes and window pointer
`timescale 1ns/1ps

module aluUnit import sparcDpPkg::*; (
    input  logic    Clk,
    input  logic    arstN,
    input  logic    aopSel,
    input  op3_t    opExt,
    input  opBSel_t opBSel,
    input  logic    flagsEn,
    input  logic    cwpWe,
    input  cwp_t    cwpIn,
    output flags_t  flags,
    output cwp_t    cwp,
    coreBusIf.alu   bus
);

    op3_t        op;
    word_t       opA;
    word_t       opB;
    word_t       result;
    logic [32:0] addFull;
    logic [32:0] subFull;
    logic        vOut;
    logic        cOut;

    assign op  = aopSel ? opExt : bus.ir[24:19];
    assign opA = bus.regA;

    always_comb begin
        case (opBSel)
            opBReg:    opB = bus.regB;
            opBSimm13: opB = {{19{bus.ir[12]}}, bus.ir[12:0]};
            opBSethi:  opB = {bus.ir[21:0], 10'b0};
            default:   opB = '0;
        endcase
    end

    // extra top bit gives carry out and borrow
    assign addFull = {1'b0, opA} + {1'b0, opB};
    assign subFull = {1'b0, opA} - {1'b0, opB};

    always_comb begin
        result = '0;
        vOut   = 1'b0;
        cOut   = 1'b0;
        case (op)
            op3Add, op3Addcc: begin
                result = addFull[31:0];
                cOut   = addFull[32];
                vOut   = (opA[31] == opB[31]) && (result[31] != opA[31]);
            end
            op3Sub, op3Subcc: begin
                result = subFull[31:0];
                cOut   = subFull[32];
                vOut   = (opA[31] != opB[31]) && (result[31] != opA[31]);
            end
            op3And, op3Andcc: result = opA & opB;
            op3Or, op3Orcc:   result = opA | opB;
            op3Xor, op3Xorcc: result = opA ^ opB;
            op3Andn:          result = opA & ~opB;
            op3Orn:           result = opA | ~opB;
            op3Xnor:          result = ~(opA ^ opB);
            // shift count is the low five bits only
            op3Sll:           result = opA << opB[4:0];
            op3Srl:           result = opA >> opB[4:0];
            op3Sra:           result = word_t'($signed(opA) >>> opB[4:0]);
            default:          result = '0;
        endcase
    end

    assign bus.aluResult = result;

    // PSR icc and CWP fields
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
            cwp   <= '0;
        end else begin
            if (flagsEn && op[4]) begin
                flags <= {result[31], (result == '0), vOut, cOut};
            end
            if (cwpWe) begin
                cwp <= cwpIn;
            end
        end
    end

endmodule

//--- rtl/coreBusIf.sv
// core bus: shared word-wide buses running between the datapath units
`timescale 1ns/1ps

interface coreBusIf import sparcDpPkg::*; ();

    // program counters
    word_t pc;
    word_t nPc;

    // memory side registers
    word_t ir;
    word_t mdr;

    // execution results and register reads
    word_t aluResult;
    word_t regA;
    word_t regB;

    modport fetch (output pc, nPc, input ir, aluResult);

    modport memory (output ir, mdr, input pc, aluResult, regA);

    modport regFile (output regA, regB, input ir, pc, nPc, mdr, aluResult);

    modport alu (output aluResult, input ir, regA, regB);

endinterface

//--- rtl/fetchUnit.sv
// fetch unit: PC and nPC registers with increment, branch, call and jump targets
`timescale 1ns/1ps

module fetchUnit import sparcDpPkg::*; (
    input  logic    Clk,
    input  logic    arstN,
    input  logic    pcEn,
    input  logic    nPcEn,
    input  nPcSel_t nPcSel,
    coreBusIf.fetch bus
);

    word_t branchOffset;
    word_t callOffset;
    word_t nPcNext;

    // disp22 sign extended, word aligned
    assign branchOffset = {{8{bus.ir[21]}}, bus.ir[21:0], 2'b00};
    // disp30 fills the whole word once shifted
    assign callOffset = {bus.ir[29:0], 2'b00};

    always_comb begin
        case (nPcSel)
            nPcIncr:   nPcNext = bus.nPc + 32'd4;
            nPcBranch: nPcNext = bus.pc + branchOffset;
            nPcCall:   nPcNext = bus.pc + callOffset;
            nPcAlu:    nPcNext = bus.aluResult;
            default:   nPcNext = bus.nPc + 32'd4;
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            bus.pc  <= pcReset;
            bus.nPc <= nPcReset;
        end else begin
            // pc always follows the old nPc
            if (pcEn) begin
                bus.pc <= bus.nPc;
            end
            if (nPcEn) begin
                bus.nPc <= nPcNext;
            end
        end
    end

    // no pc or nPc load requested while reset is low
    assert property (@(posedge Clk)
        !arstN |-> !pcEn && !nPcEn)
        else $error("pc or nPc load requested during reset");

endmodule

//--- rtl/memoryUnit.sv
// memory unit: MAR, MDR and IR around a word memory with one-cycle completion
`timescale 1ns/1ps

module memoryUnit import sparcDpPkg::*; #(
    parameter int memWords = 64
) (
    input  logic    Clk,
    input  logic    arstN,
    input  logic    marEn,
    input  logic    mdrEn,
    input  logic    irEn,
    input  logic    memStart,
    input  logic    memWrite,
    input  marSel_t marSel,
    input  mdrSel_t mdrSel,
    input  word_t   extAddr,
    input  word_t   extData,
    output logic    memDone,
    coreBusIf.memory bus
);

    localparam int idxBits = $clog2(memWords);

    typedef logic [idxBits-1:0] memIdx_t;

    word_t   mar;
    word_t   marNext;
    word_t   mdrNext;
    word_t   readData;
    memIdx_t memIdx;

    word_t mem [memWords];

    // word index, byte offset dropped
    assign memIdx   = mar[idxBits+1:2];
    assign readData = mem[memIdx];

    always_comb begin
        case (marSel)
            marAlu:  marNext = bus.aluResult;
            marPc:   marNext = bus.pc;
            marExt:  marNext = extAddr;
            default: marNext = '0;
        endcase
    end

    always_comb begin
        case (mdrSel)
            mdrMem:  mdrNext = readData;
            mdrRegA: mdrNext = bus.regA;
            mdrExt:  mdrNext = extData;
            default: mdrNext = '0;
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            mar     <= '0;
            bus.mdr <= '0;
            bus.ir  <= '0;
            memDone <= 1'b0;
        end else begin
            if (marEn) begin
                mar <= marNext;
            end
            if (mdrEn) begin
                bus.mdr <= mdrNext;
            end
            // instruction always comes through the MDR
            if (irEn) begin
                bus.ir <= bus.mdr;
            end
            memDone <= memStart;
        end
    end

    always_ff @(posedge Clk) begin
        if (memStart && memWrite) begin
            mem[memIdx] <= bus.mdr;
        end
    end

    // control unit must wait for completion before the next start
    assert property (@(posedge Clk) disable iff (!arstN)
        memStart |-> !memDone)
        else $error("memStart issued while memDone is high");

endmodule

//--- rtl/regFile.sv
// windowed register file: globals plus overlapping windows, two reads and one write
`timescale 1ns/1ps

module regFile import sparcDpPkg::*; (
    input  logic    Clk,
    input  logic    rfWe,
    input  logic    raSel,
    input  logic    rcSel,
    input  cinSel_t cinSel,
    input  cwp_t    cwp,
    coreBusIf.regFile bus
);

    localparam int windowRegs = numWindows * windowStride;
    localparam int physRegs   = numGlobals + windowRegs;
    localparam int physBits   = $clog2(physRegs);

    typedef logic [physBits-1:0] physAddr_t;

    regAddr_t  raAddr;
    regAddr_t  rbAddr;
    regAddr_t  rcAddr;
    physAddr_t raPhys;
    physAddr_t rbPhys;
    physAddr_t rcPhys;
    word_t     cin;

    word_t regs [physRegs];

    // outs of window w land on the ins of window w-1
    function automatic physAddr_t mapReg(regAddr_t r, cwp_t w);
        int offset;
        if (r < regAddr_t'(numGlobals)) begin
            return physAddr_t'(r);
        end
        offset = (int'(w) * windowStride + int'(r) - numGlobals) % windowRegs;
        return physAddr_t'(numGlobals + offset);
    endfunction

    assign raAddr = raSel ? bus.ir[29:25] : bus.ir[18:14];
    assign rbAddr = bus.ir[4:0];
    assign rcAddr = rcSel ? regLink : bus.ir[29:25];

    assign raPhys = mapReg(raAddr, cwp);
    assign rbPhys = mapReg(rbAddr, cwp);
    assign rcPhys = mapReg(rcAddr, cwp);

    always_comb begin
        case (cinSel)
            cinPc:   cin = bus.pc;
            cinNPc:  cin = bus.nPc;
            cinAlu:  cin = bus.aluResult;
            cinMdr:  cin = bus.mdr;
            default: cin = bus.aluResult;
        endcase
    end

    // r0 is hardwired to zero on both read ports
    assign bus.regA = (raAddr == '0) ? '0 : regs[raPhys];
    assign bus.regB = (rbAddr == '0) ? '0 : regs[rbPhys];

    always_ff @(posedge Clk) begin
        if (rfWe && (rcAddr != '0)) begin
            regs[rcPhys] <= cin;
        end
    end

    assert property (@(posedge Clk) rfWe |-> !$isunknown(cwp))
        else $error("register write with unknown cwp");

endmodule

//--- rtl/sparcDataPath.sv
// sparc datapath top: fetch, memory, register file and ALU units on one core bus
`timescale 1ns/1ps

module sparcDataPath import sparcDpPkg::*; #(
    parameter int memWords = 64
) (
    input  logic    Clk,
    input  logic    arstN,
    // fetch controls
    input  logic    pcEn,
    input  logic    nPcEn,
    input  nPcSel_t nPcSel,
    // memory controls
    input  logic    marEn,
    input  logic    mdrEn,
    input  logic    irEn,
    input  logic    memStart,
    input  logic    memWrite,
    input  marSel_t marSel,
    input  mdrSel_t mdrSel,
    input  word_t   extAddr,
    input  word_t   extData,
    // register file controls
    input  logic    rfWe,
    input  logic    raSel,
    input  logic    rcSel,
    input  cinSel_t cinSel,
    // ALU and PSR controls
    input  logic    aopSel,
    input  op3_t    opExt,
    input  opBSel_t opBSel,
    input  logic    flagsEn,
    input  logic    cwpWe,
    input  cwp_t    cwpIn,
    // observation
    output word_t   pc,
    output word_t   nPc,
    output word_t   ir,
    output word_t   mdr,
    output word_t   aluResult,
    output flags_t  flags,
    output cwp_t    cwp,
    output logic    memDone
);

    coreBusIf bus ();

    fetchUnit uFetch (
        .Clk(Clk), .arstN(arstN), .pcEn(pcEn), .nPcEn(nPcEn), .nPcSel(nPcSel),
        .bus(bus.fetch)
    );

    memoryUnit #(.memWords(memWords)) uMemory (
        .Clk(Clk), .arstN(arstN), .marEn(marEn), .mdrEn(mdrEn), .irEn(irEn),
        .memStart(memStart), .memWrite(memWrite), .marSel(marSel), .mdrSel(mdrSel),
        .extAddr(extAddr), .extData(extData), .memDone(memDone),
        .bus(bus.memory)
    );

    // window pointer comes back from the PSR in the ALU unit
    regFile uRegFile (
        .Clk(Clk), .rfWe(rfWe), .raSel(raSel), .rcSel(rcSel), .cinSel(cinSel),
        .cwp(cwp), .bus(bus.regFile)
    );

    aluUnit uAlu (
        .Clk(Clk), .arstN(arstN), .aopSel(aopSel), .opExt(opExt), .opBSel(opBSel),
        .flagsEn(flagsEn), .cwpWe(cwpWe), .cwpIn(cwpIn), .flags(flags), .cwp(cwp),
        .bus(bus.alu)
    );

    assign pc        = bus.pc;
    assign nPc       = bus.nPc;
    assign ir        = bus.ir;
    assign mdr       = bus.mdr;
    assign aluResult = bus.aluResult;

endmodule

//--- rtl/sparcDpPkg.sv
// sparc datapath package: word and field types, select codes, ALU opcodes and constants
package sparcDpPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [1:0]  cwp_t;
    typedef logic [5:0]  op3_t;
    // N Z V C, N on top
    typedef logic [3:0]  flags_t;

    typedef enum logic [1:0] {nPcIncr, nPcBranch, nPcCall, nPcAlu} nPcSel_t;
    typedef enum logic [1:0] {marAlu, marPc, marExt} marSel_t;
    typedef enum logic [1:0] {mdrMem, mdrRegA, mdrExt} mdrSel_t;
    // fourth code feeds zero to the ALU
    typedef enum logic [1:0] {opBReg, opBSimm13, opBSethi} opBSel_t;
    typedef enum logic [1:0] {cinPc, cinNPc, cinAlu, cinMdr} cinSel_t;

    // register window geometry
    localparam int numWindows   = 4;
    localparam int windowStride = 16;
    localparam int numGlobals   = 8;

    // call link destination
    localparam regAddr_t regLink = 5'd15;

    // op3 encodings, bit 4 marks the cc variants
    localparam op3_t op3Add   = 6'b000000;
    localparam op3_t op3And   = 6'b000001;
    localparam op3_t op3Or    = 6'b000010;
    localparam op3_t op3Xor   = 6'b000011;
    localparam op3_t op3Sub   = 6'b000100;
    localparam op3_t op3Andn  = 6'b000101;
    localparam op3_t op3Orn   = 6'b000110;
    localparam op3_t op3Xnor  = 6'b000111;
    localparam op3_t op3Addcc = 6'b010000;
    localparam op3_t op3Andcc = 6'b010001;
    localparam op3_t op3Orcc  = 6'b010010;
    localparam op3_t op3Xorcc = 6'b010011;
    localparam op3_t op3Subcc = 6'b010100;
    localparam op3_t op3Sll   = 6'b100101;
    localparam op3_t op3Srl   = 6'b100110;
    localparam op3_t op3Sra   = 6'b100111;

    // program counter values after reset
    localparam word_t pcReset  = 32'h0000_0000;
    localparam word_t nPcReset = 32'h0000_0004;

endpackage

//--- run.sh
#!/bin/sh
# builds the sparc datapath testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sparcDataPath.f \
    --top-module sparcDataPathTb -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

//--- sparcDataPath.f
rtl/sparcDpPkg.sv
rtl/coreBusIf.sv
rtl/fetchUnit.sv
rtl/memoryUnit.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/sparcDataPath.sv
bench/sparcDataPathTb.sv
